/* source/aluPkg.sv */
package aluPkg;

    localparam int REG_COUNT = 32;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [3:0]  aluOp_t;

    // bit 2 selects subtract in the adder.
    localparam aluOp_t ALU_AND = 4'b0000;
    localparam aluOp_t ALU_OR  = 4'b0001;
    localparam aluOp_t ALU_ADD = 4'b0010;
    localparam aluOp_t ALU_XOR = 4'b0011;
    localparam aluOp_t ALU_SUB = 4'b0110;
    localparam aluOp_t ALU_SLT = 4'b0111;
    localparam aluOp_t ALU_NOR = 4'b1000;
    localparam aluOp_t ALU_SLL = 4'b1001;
    localparam aluOp_t ALU_SRL = 4'b1010;

    // standard mips opcodes.
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_XORI  = 6'h0e;
    localparam logic [5:0] OP_LUI   = 6'h0f;

    // r-type funct field.
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SLLV = 6'h04;
    localparam logic [5:0] FN_SRLV = 6'h06;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;

endpackage

/* source/instrDecoder.sv */
module instrDecoder (
    input  aluPkg::word_t    instr,
    input  logic             instrValid,
    output aluPkg::aluOp_t   aluOp,
    output logic             useImm,
    output logic             zeroExtend,
    output logic             isLui,
    output logic             shiftByShamt,
    output logic             regWrite,
    output aluPkg::regAddr_t destAddr,
    output logic             isBranch,
    output logic             branchOnEqual,
    output logic             illegal
);
    import aluPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        aluOp         = ALU_ADD;
        useImm        = 1'b0;
        zeroExtend    = 1'b0;
        isLui         = 1'b0;
        shiftByShamt  = 1'b0;
        regWrite      = 1'b0;
        destAddr      = '0;
        isBranch      = 1'b0;
        branchOnEqual = 1'b0;
        illegal       = 1'b0;
        if (instrValid) begin
            case (opcode)
                OP_RTYPE: begin
                    regWrite = 1'b1;
                    destAddr = instr[15:11]; // rd.
                    case (funct)
                        FN_ADD:  aluOp = ALU_ADD;
                        FN_SUB:  aluOp = ALU_SUB;
                        FN_AND:  aluOp = ALU_AND;
                        FN_OR:   aluOp = ALU_OR;
                        FN_XOR:  aluOp = ALU_XOR;
                        FN_NOR:  aluOp = ALU_NOR;
                        FN_SLT:  aluOp = ALU_SLT;
                        FN_SLLV: aluOp = ALU_SLL;
                        FN_SRLV: aluOp = ALU_SRL;
                        FN_SLL: begin
                            aluOp        = ALU_SLL;
                            shiftByShamt = 1'b1;
                        end
                        FN_SRL: begin
                            aluOp        = ALU_SRL;
                            shiftByShamt = 1'b1;
                        end
                        default: begin
                            regWrite = 1'b0;
                            illegal  = 1'b1;
                        end
                    endcase
                end
                OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                    useImm   = 1'b1;
                    regWrite = 1'b1;
                    destAddr = instr[20:16]; // rt.
                    case (opcode)
                        OP_SLTI: aluOp = ALU_SLT;
                        OP_ANDI: aluOp = ALU_AND;
                        OP_ORI:  aluOp = ALU_OR;
                        OP_XORI: aluOp = ALU_XOR;
                        OP_LUI:  aluOp = ALU_OR;
                        default: aluOp = ALU_ADD;
                    endcase
                    zeroExtend = (opcode == OP_ANDI) || (opcode == OP_ORI) ||
                                 (opcode == OP_XORI);
                    isLui      = (opcode == OP_LUI);
                end
                OP_BEQ, OP_BNE: begin
                    aluOp         = ALU_SUB; // compare by difference.
                    isBranch      = 1'b1;
                    branchOnEqual = (opcode == OP_BEQ);
                end
                default: illegal = 1'b1;
            endcase
        end
    end

endmodule

/* source/operandSelect.sv */
module operandSelect (
    input  aluPkg::word_t rsValue,
    input  aluPkg::word_t rtValue,
    input  logic [15:0]   imm16,
    input  logic [4:0]    shamt,
    input  logic          useImm,
    input  logic          zeroExtend,
    input  logic          isLui,
    input  logic          shiftByShamt,
    output aluPkg::word_t leftOperand,
    output aluPkg::word_t rightOperand
);
    import aluPkg::*;

    word_t immExt;
    word_t luiValue;

    // andi, ori and xori take the zero-extended form.
    assign immExt   = zeroExtend ? {16'b0, imm16} : {{16{imm16[15]}}, imm16};
    assign luiValue = {imm16, 16'b0};

    // shifts move rightOperand by leftOperand[4:0].
    always_comb begin
        if (isLui) begin
            leftOperand = '0; // or'd with the lui constant.
        end else if (shiftByShamt) begin
            leftOperand = {27'b0, shamt};
        end else begin
            leftOperand = rsValue;
        end
    end

    always_comb begin
        if (isLui) begin
            rightOperand = luiValue;
        end else if (useImm) begin
            rightOperand = immExt;
        end else begin
            rightOperand = rtValue;
        end
    end

endmodule

/* source/regFile.sv */
module regFile (
    input  logic             clk,
    input  logic             rstN,
    input  aluPkg::regAddr_t readAddrA,
    input  aluPkg::regAddr_t readAddrB,
    output aluPkg::word_t    readDataA,
    output aluPkg::word_t    readDataB,
    input  logic             writeEn,
    input  aluPkg::regAddr_t writeAddr,
    input  aluPkg::word_t    writeData
);
    import aluPkg::*;

    word_t regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // pending writeback is bypassed, so the next instruction sees it.
    always_comb begin
        if (readAddrA == '0) begin
            readDataA = '0;
        end else if (writeEn && writeAddr == readAddrA) begin
            readDataA = writeData;
        end else begin
            readDataA = regs[readAddrA];
        end
    end

    always_comb begin
        if (readAddrB == '0) begin
            readDataB = '0;
        end else if (writeEn && writeAddr == readAddrB) begin
            readDataB = writeData;
        end else begin
            readDataB = regs[readAddrB];
        end
    end

endmodule

/* source/alu32.sv */
module alu32 (
    input  aluPkg::aluOp_t aluOp,
    input  aluPkg::word_t  leftOperand,
    input  aluPkg::word_t  rightOperand,
    output aluPkg::word_t  aluResult,
    output logic           zero
);
    import aluPkg::*;

    word_t      addSubResult;
    word_t      addendB;
    logic       subtract;
    logic [4:0] shiftAmount;
    word_t      shiftLeftResult;
    word_t      shiftRightResult;

    assign subtract = aluOp[2];

    // two's complement subtract, wraps on overflow.
    assign addendB      = subtract ? ~rightOperand : rightOperand;
    assign addSubResult = leftOperand + addendB + {31'b0, subtract};

    assign shiftAmount      = leftOperand[4:0];
    assign shiftLeftResult  = rightOperand << shiftAmount;
    assign shiftRightResult = rightOperand >> shiftAmount; // logical only.

    always_comb begin
        case (aluOp)
            ALU_ADD: aluResult = addSubResult;
            ALU_SUB: aluResult = addSubResult;
            ALU_AND: aluResult = leftOperand & rightOperand;
            ALU_OR:  aluResult = leftOperand | rightOperand;
            ALU_XOR: aluResult = leftOperand ^ rightOperand;
            ALU_NOR: aluResult = ~(leftOperand | rightOperand);
            ALU_SLT: aluResult = {31'b0, addSubResult[31]}; // sign of wrapped difference.
            ALU_SLL: aluResult = shiftLeftResult;
            ALU_SRL: aluResult = shiftRightResult;
            default: aluResult = '0;
        endcase
    end

    assign zero = (aluResult == '0);

endmodule

/* source/executeCore.sv */
module executeCore (
    input  logic             clk,
    input  logic             rstN,
    input  aluPkg::word_t    instr,
    input  logic             instrValid,
    output logic             wbValid,
    output aluPkg::regAddr_t wbAddr,
    output aluPkg::word_t    wbData,
    output logic             branchValid,
    output logic             branchTaken,
    output logic             illegalInstr
);
    import aluPkg::*;

    aluOp_t   aluOp;
    logic     useImm;
    logic     zeroExtend;
    logic     isLui;
    logic     shiftByShamt;
    logic     regWrite;
    regAddr_t destAddr;
    logic     isBranch;
    logic     branchOnEqual;
    logic     illegal;
    word_t    rsValue;
    word_t    rtValue;
    word_t    leftOperand;
    word_t    rightOperand;
    word_t    aluResult;
    logic     zero;

    instrDecoder u_instrDecoder (
        .instr(instr), .instrValid(instrValid), .aluOp(aluOp),
        .useImm(useImm), .zeroExtend(zeroExtend), .isLui(isLui),
        .shiftByShamt(shiftByShamt), .regWrite(regWrite), .destAddr(destAddr),
        .isBranch(isBranch), .branchOnEqual(branchOnEqual), .illegal(illegal)
    );

    regFile u_regFile (
        .clk(clk), .rstN(rstN),
        .readAddrA(instr[25:21]), .readAddrB(instr[20:16]), // rs, rt.
        .readDataA(rsValue), .readDataB(rtValue),
        .writeEn(wbValid), .writeAddr(wbAddr), .writeData(wbData)
    );

    operandSelect u_operandSelect (
        .rsValue(rsValue), .rtValue(rtValue),
        .imm16(instr[15:0]), .shamt(instr[10:6]),
        .useImm(useImm), .zeroExtend(zeroExtend), .isLui(isLui),
        .shiftByShamt(shiftByShamt),
        .leftOperand(leftOperand), .rightOperand(rightOperand)
    );

    alu32 u_alu32 (
        .aluOp(aluOp), .leftOperand(leftOperand), .rightOperand(rightOperand),
        .aluResult(aluResult), .zero(zero)
    );

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbValid      <= 1'b0;
            branchValid  <= 1'b0;
            branchTaken  <= 1'b0;
            illegalInstr <= 1'b0;
        end else begin
            wbValid      <= regWrite && (destAddr != '0); // r0 never written.
            branchValid  <= isBranch;
            branchTaken  <= isBranch && (branchOnEqual ? zero : !zero);
            illegalInstr <= illegal;
        end
    end

    always_ff @(posedge clk) begin
        wbAddr <= destAddr;
        wbData <= aluResult;
    end

endmodule

/* testbench/tb_executeCore.sv */
module tb_executeCore;
    import aluPkg::*;

    localparam int maxCycles = 400; // roughly twice the summed test length.

    logic     clk;
    logic     rstN;
    word_t    instr;
    logic     instrValid;
    logic     wbValid;
    regAddr_t wbAddr;
    word_t    wbData;
    logic     branchValid;
    logic     branchTaken;
    logic     illegalInstr;

    word_t  model [REG_COUNT]; // shadow register file.
    integer seed = 96;
    int     cycleCount = 0;
    int     errorCount = 0;
    int     testErrors = 0;
    int     testsRun = 0;
    int     testsFailed = 0;
    string  testName;

    executeCore u_executeCore (
        .clk(clk), .rstN(rstN), .instr(instr), .instrValid(instrValid),
        .wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData),
        .branchValid(branchValid), .branchTaken(branchTaken), .illegalInstr(illegalInstr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= maxCycles) begin
            $display("run stopped, no finish after %0d cycles", cycleCount);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic word_t rType(input logic [5:0] fn, input regAddr_t rs, input regAddr_t rt,
                                    input regAddr_t rd, input logic [4:0] sh);
        rType = {OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t iType(input logic [5:0] op, input regAddr_t rs, input regAddr_t rt,
                                    input logic [15:0] imm);
        iType = {op, rs, rt, imm};
    endfunction

    function automatic regAddr_t pickReg(input int lo, input int span);
        pickReg = regAddr_t'(lo + ($unsigned($random(seed)) % span));
    endfunction

    task automatic checkWord(input string field, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Mismatch in %s (%s): expected %h, actual %h",
                     testName, field, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkAddr(input string field, input regAddr_t expected,
                             input regAddr_t actual);
        if (actual !== expected) begin
            $display("Mismatch in %s (%s): expected %0d, actual %0d",
                     testName, field, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkFlag(input string field, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Mismatch in %s (%s): expected %b, actual %b",
                     testName, field, expected, actual);
            errorCount++;
        end
    endtask

    // expected behavior straight from the instruction semantics.
    task automatic predict(input word_t ins, output logic wr, output regAddr_t dst,
                           output word_t res, output logic br, output logic taken,
                           output logic ill);
        logic [5:0] op;
        logic [5:0] fn;
        word_t      a;
        word_t      b;
        word_t      sext;
        word_t      zext;
        word_t      diff;
        op   = ins[31:26];
        fn   = ins[5:0];
        a    = model[ins[25:21]];
        b    = model[ins[20:16]];
        sext = {{16{ins[15]}}, ins[15:0]};
        zext = {16'b0, ins[15:0]};
        wr   = 1'b1;
        dst  = ins[20:16];
        res  = '0;
        br   = 1'b0;
        taken = 1'b0;
        ill  = 1'b0;
        case (op)
            OP_RTYPE: begin
                dst = ins[15:11];
                diff = a - b;
                case (fn)
                    FN_ADD:  res = a + b;
                    FN_SUB:  res = diff;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_NOR:  res = ~(a | b);
                    FN_SLT:  res = {31'b0, diff[31]};
                    FN_SLL:  res = b << ins[10:6];
                    FN_SRL:  res = b >> ins[10:6];
                    FN_SLLV: res = b << a[4:0];
                    FN_SRLV: res = b >> a[4:0];
                    default: begin
                        wr  = 1'b0;
                        ill = 1'b1;
                    end
                endcase
            end
            OP_ADDI: res = a + sext;
            OP_SLTI: begin
                diff = a - sext;
                res  = {31'b0, diff[31]};
            end
            OP_ANDI: res = a & zext;
            OP_ORI:  res = a | zext;
            OP_XORI: res = a ^ zext;
            OP_LUI:  res = {ins[15:0], 16'b0};
            OP_BEQ, OP_BNE: begin
                wr    = 1'b0;
                br    = 1'b1;
                taken = (op == OP_BEQ) ? (a == b) : (a != b);
            end
            default: begin
                wr  = 1'b0;
                ill = 1'b1;
            end
        endcase
        wr = wr && (dst != '0); // r0 is never written.
    endtask

    // one instruction per cycle, checked just after the edge that registers it.
    task automatic execute(input word_t ins);
        logic     expWb;
        regAddr_t expAddr;
        word_t    expData;
        logic     expBr;
        logic     expTaken;
        logic     expIll;
        predict(ins, expWb, expAddr, expData, expBr, expTaken, expIll);
        instr      = ins;
        instrValid = 1'b1;
        @(posedge clk);
        #2;
        checkFlag("wbValid", expWb, wbValid);
        if (expWb) begin
            checkAddr("wbAddr", expAddr, wbAddr);
            checkWord("wbData", expData, wbData);
            model[expAddr] = expData;
        end
        checkFlag("branchValid", expBr, branchValid);
        checkFlag("branchTaken", expTaken, branchTaken);
        checkFlag("illegalInstr", expIll, illegalInstr);
    endtask

    task automatic loadReg(input regAddr_t r, input word_t value);
        execute(iType(OP_LUI, 5'd0, r, value[31:16]));
        execute(iType(OP_ORI, r, r, value[15:0]));
    endtask

    task automatic startTest(input string name);
        testName   = name;
        testErrors = errorCount;
    endtask

    task automatic endTest();
        instrValid = 1'b0;
        instr      = '0;
        @(posedge clk);
        #2;
        testsRun++;
        if (errorCount != testErrors) begin
            testsFailed++;
        end
        $display("%s finished, %0d errors", testName, errorCount - testErrors);
    endtask

    task automatic resetTest();
        startTest("reset");
        checkFlag("wbValid", 1'b0, wbValid);
        checkFlag("branchValid", 1'b0, branchValid);
        checkFlag("illegalInstr", 1'b0, illegalInstr);
        execute(rType(FN_ADD, 5'd1, 5'd2, 5'd3, 5'd0));
        endTest();
    endtask

    task automatic arithTest();
        logic [5:0] ops [6];
        ops = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_NOR};
        startTest("arith");
        for (int r = 1; r <= 8; r++) begin
            loadReg(regAddr_t'(r), $random(seed));
        end
        execute(iType(OP_ADDI, 5'd0, 5'd9, 16'($random(seed))));
        for (int k = 0; k < 4; k++) begin
            foreach (ops[i]) begin
                execute(rType(ops[i], pickReg(1, 9), pickReg(1, 9), pickReg(10, 11), 5'd0));
            end
        end
        endTest();
    endtask

    task automatic compareTest();
        logic [15:0] imm;
        startTest("compare");
        for (int r = 1; r <= 4; r++) begin
            loadReg(regAddr_t'(r), $random(seed));
        end
        execute(rType(FN_SLT, 5'd2, 5'd2, 5'd10, 5'd0)); // equal gives 0.
        for (int k = 0; k < 6; k++) begin
            execute(rType(FN_SLT, pickReg(1, 4), pickReg(1, 4), 5'd11, 5'd0));
            execute(iType(OP_SLTI, pickReg(1, 4), 5'd12, 16'($random(seed))));
        end
        for (int k = 0; k < 3; k++) begin
            imm = 16'($random(seed)) | 16'h8000; // top bit set shows the extension.
            execute(iType(OP_ANDI, pickReg(1, 4), 5'd13, imm));
            execute(iType(OP_ORI, pickReg(1, 4), 5'd14, imm));
            execute(iType(OP_XORI, pickReg(1, 4), 5'd15, imm));
            execute(iType(OP_ADDI, pickReg(1, 4), 5'd16, imm));
        end
        endTest();
    endtask

    task automatic shiftTest();
        startTest("shift");
        loadReg(5'd5, $random(seed));
        for (int s = 0; s < 32; s++) begin
            execute(rType(FN_SLL, 5'd0, 5'd5, 5'd6, 5'(s)));
            execute(rType(FN_SRL, 5'd0, 5'd5, 5'd7, 5'(s)));
        end
        for (int k = 0; k < 8; k++) begin
            execute(iType(OP_ADDI, 5'd0, 5'd8, 16'($random(seed))));
            execute(rType(FN_SLLV, 5'd8, 5'd5, 5'd9, 5'd0));
            execute(rType(FN_SRLV, 5'd8, 5'd5, 5'd9, 5'd0));
        end
        endTest();
    endtask

    task automatic branchTest();
        startTest("branch");
        execute(iType(OP_ADDI, 5'd0, 5'd21, 16'h1357));
        execute(iType(OP_ADDI, 5'd0, 5'd22, 16'h1357));
        execute(iType(OP_ADDI, 5'd0, 5'd23, 16'h9abc));
        execute(iType(OP_BEQ, 5'd21, 5'd22, 16'h0010));
        execute(iType(OP_BNE, 5'd21, 5'd22, 16'h0010));
        execute(iType(OP_BEQ, 5'd21, 5'd23, 16'hfff0));
        execute(iType(OP_BNE, 5'd21, 5'd23, 16'hfff0));
        endTest();
    endtask

    task automatic cornerTest();
        startTest("corner");
        execute(iType(OP_ADDI, 5'd0, 5'd0, 16'h0055));
        execute(rType(FN_OR, 5'd0, 5'd0, 5'd10, 5'd0));
        execute(iType(6'h3f, 5'd5, 5'd5, 16'h1234));
        execute(rType(6'h3f, 5'd5, 5'd5, 5'd5, 5'd0));
        execute(rType(FN_OR, 5'd5, 5'd0, 5'd11, 5'd0)); // r5 must be untouched.
        execute(iType(OP_ADDI, 5'd0, 5'd12, 16'($random(seed))));
        execute(rType(FN_ADD, 5'd12, 5'd12, 5'd13, 5'd0));
        execute(rType(FN_SUB, 5'd13, 5'd12, 5'd14, 5'd0));
        endTest();
    endtask

    initial begin
        rstN       = 1'b0;
        instr      = '0;
        instrValid = 1'b0;
        for (int i = 0; i < REG_COUNT; i++) begin
            model[i] = '0;
        end
        repeat (5) @(posedge clk);
        #2;
        rstN = 1'b1;
        resetTest();
        arithTest();
        compareTest();
        shiftTest();
        branchTest();
        cornerTest();
        $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* compile.f */
source/aluPkg.sv
source/instrDecoder.sv
source/operandSelect.sv
source/regFile.sv
source/alu32.sv
source/executeCore.sv
testbench/tb_executeCore.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_executeCore -f compile.f -o simExecuteCore

output=$(./obj_dir/simExecuteCore)
echo "$output"

if echo "$output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1
